// File: common/riscv_pkg.sv
package riscv_pkg;

    // Datapath and register file widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // RV32I major opcodes handled by decode
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111
    } t_opcode;

    // Branch conditions, 3'b010 and 3'b011 are unused
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } t_funct3;

    typedef logic [6:0] t_funct7;

    // Immediate layout selected by the opcode
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_none
    } t_imm_fmt;

    typedef struct packed {
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     reg_write;
        t_imm_fmt imm_fmt;
        logic     illegal;
    } dec_ctrl_t;

    // Everything the execute stage needs for one instruction
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [reg_addr_w-1:0] rd;
        t_funct3               funct3;
        t_funct7               funct7;
        dec_ctrl_t             ctrl;
    } ex_bundle_t;

    // Redirect request back to fetch
    typedef struct packed {
        logic            redirect;
        logic [xlen-1:0] target;
    } if_ctrl_t;

endpackage

// File: decode/control_unit.sv
`timescale 1ns/100ps

module control_unit import riscv_pkg::*; (
    input  t_opcode   opcode,
    input  t_funct3   funct3,
    output dec_ctrl_t ctrl
);

    logic funct3_ok;

    // Only six of the eight funct3 codes name a branch condition
    always_comb begin
        case (funct3)
            beq, bne, blt, bge, bltu, bgeu: funct3_ok = 1'b1;
            default:                        funct3_ok = 1'b0;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.imm_fmt = imm_none;

        case (opcode)
            op: begin
                ctrl.reg_write = 1'b1;
            end
            op_imm, load: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_fmt   = imm_i;
            end
            store: begin
                ctrl.imm_fmt = imm_s;
            end
            branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.imm_fmt   = imm_b;
                ctrl.illegal   = !funct3_ok;
            end
            jal: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm_fmt   = imm_j;
            end
            jalr: begin
                ctrl.is_jalr   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm_fmt   = imm_i;
            end
            lui, auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_fmt   = imm_u;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // Illegal instructions must neither write back nor steer fetch
        if (ctrl.illegal) begin
            ctrl.reg_write = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
    end

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import riscv_pkg::*; (
    input  logic [xlen-1:0] instruction,
    input  t_imm_fmt        imm_fmt,
    output logic [xlen-1:0] imm
);

    logic sign;

    // Every format takes its sign from bit 31
    assign sign = instruction[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            imm_s: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            imm_b: begin
                // Branch offsets are in halfwords, bit 0 is implicit
                imm = {{19{sign}},
                       instruction[31],
                       instruction[7],
                       instruction[30:25],
                       instruction[11:8],
                       1'b0};
            end
            imm_u: begin
                imm = {instruction[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{11{sign}},
                       instruction[31],
                       instruction[19:12],
                       instruction[20],
                       instruction[30:21],
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: decode/register_file.sv
`timescale 1ns/100ps

module register_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [xlen-1:0]       write_data,
    output logic [xlen-1:0]       read_data1,
    output logic [xlen-1:0]       read_data2
);

    // x0 has no storage
    logic [xlen-1:0] regs [num_regs-1:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 1; k < num_regs; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= write_data;
        end
    end

    // Reads see stored state only, no bypass of a same-edge write
    always_comb begin
        if (rs1 == '0) begin
            read_data1 = '0;
        end else begin
            read_data1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            read_data2 = '0;
        end else begin
            read_data2 = regs[rs2];
        end
    end

    a_x0_reads_zero: assert property (
        @(posedge clk) ((rs1 == '0) |-> (read_data1 == '0)) and
                       ((rs2 == '0) |-> (read_data2 == '0))
    ) else $error("x0 read returned a nonzero value");

endmodule

// File: decode/bu.sv
`timescale 1ns/100ps

module bu import riscv_pkg::*; (
    input  dec_ctrl_t       ctrl,
    input  t_funct3         funct3,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output if_ctrl_t        if_ctrl
);

    logic            cond;
    logic            take_branch;
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    always_comb begin
        case (funct3)
            beq:     cond = (rs1_data == rs2_data);
            bne:     cond = (rs1_data != rs2_data);
            blt:     cond = ($signed(rs1_data) <  $signed(rs2_data));
            bge:     cond = ($signed(rs1_data) >= $signed(rs2_data));
            bltu:    cond = (rs1_data <  rs2_data);
            bgeu:    cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    // Comparison only matters for a real branch
    assign take_branch = ctrl.is_branch & cond;

    // JALR is register relative, everything else PC relative
    assign base = ctrl.is_jalr ? rs1_data : pc;
    assign sum  = base + imm;

    assign if_ctrl.redirect = ctrl.is_jal | ctrl.is_jalr | take_branch;
    assign if_ctrl.target   = ctrl.is_jalr ? {sum[xlen-1:1], 1'b0} : sum;

endmodule

// File: decode/dec.sv
`timescale 1ns/100ps

module dec import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  id_valid,
    input  logic [xlen-1:0]       instruction,
    input  logic [xlen-1:0]       pc,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  ex_valid,
    output ex_bundle_t            ex_bundle,
    output if_ctrl_t              if_ctrl
);

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    t_funct3               funct3;
    t_funct7               funct7;
    t_opcode               opcode;

    dec_ctrl_t       ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    if_ctrl_t        bu_if_ctrl;
    ex_bundle_t      bundle_d;

    logic            redirect_q;
    logic [xlen-1:0] target_q;

    // Instruction fields
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign rd     = instruction[11:7];
    assign funct3 = t_funct3'(instruction[14:12]);
    assign funct7 = t_funct7'(instruction[31:25]);
    assign opcode = t_opcode'(instruction[6:0]);

    control_unit ctrl_unit (
        .opcode (opcode),
        .funct3 (funct3),
        .ctrl   (ctrl)
    );

    imm_gen imm_gen_unit (
        .instruction (instruction),
        .imm_fmt     (ctrl.imm_fmt),
        .imm         (imm)
    );

    register_file register_file_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .we         (wb_we),
        .rd         (wb_rd),
        .write_data (wb_data),
        .read_data1 (rs1_data),
        .read_data2 (rs2_data)
    );

    bu bu_unit (
        .ctrl     (ctrl),
        .funct3   (funct3),
        .pc       (pc),
        .imm      (imm),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .if_ctrl  (bu_if_ctrl)
    );

    assign bundle_d = '{pc: pc, imm: imm, rs1_data: rs1_data, rs2_data: rs2_data,
                        rd: rd, funct3: funct3, funct7: funct7, ctrl: ctrl};

    // Redirect gated by id_valid so idle cycles never steer fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            ex_valid   <= id_valid;
            redirect_q <= id_valid & bu_if_ctrl.redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_bundle <= bundle_d;
            target_q  <= bu_if_ctrl.target;
        end
    end

    assign if_ctrl = '{redirect: redirect_q, target: target_q};

    a_redirect_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) if_ctrl.redirect |-> ex_valid
    ) else $error("redirect raised without ex_valid");

endmodule

// File: source/id_stage_top.sv
`timescale 1ns/100ps

module id_stage_top import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    // Fetched instruction
    input  logic                  id_valid,
    input  logic [xlen-1:0]       instruction,
    input  logic [xlen-1:0]       pc,

    // Write-back port
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,

    // To execute and back to fetch
    output logic                  ex_valid,
    output ex_bundle_t            ex_bundle,
    output if_ctrl_t              if_ctrl
);

    dec dec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .instruction (instruction),
        .pc          (pc),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_bundle   (ex_bundle),
        .if_ctrl     (if_ctrl)
    );

endmodule

// File: dv/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage import riscv_pkg::*; ();

    typedef struct packed {
        ex_bundle_t b;
        if_ctrl_t   c;
    } expect_t;

    // Cycles spent in reset and in every test section below
    localparam int reset_cycles = 16;
    localparam int num_rand     = 400;
    localparam int stim_cycles  = reset_cycles + 34 + 84 + 110 + 44 + 30 + num_rand + 4;
    localparam int period_ns    = 40;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  id_valid;
    logic [xlen-1:0]       instruction;
    logic [xlen-1:0]       pc;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  ex_valid;
    ex_bundle_t            ex_bundle;
    if_ctrl_t              if_ctrl;

    logic [31:0] shadow [num_regs];
    logic [31:0] rng_state = 32'd25503;
    expect_t     exp_q [$];

    // Operand registers for the branch section, x1..x6
    logic [31:0] br_val [7] = '{32'h0, 32'h1234_5678, 32'h1234_5678, 32'hFFFF_FFFB,
                               32'h3, 32'h8000_0000, 32'h1};
    logic [4:0]  br_rs1 [6] = '{5'd1, 5'd3, 5'd5, 5'd2, 5'd4, 5'd6};
    logic [4:0]  br_rs2 [6] = '{5'd2, 5'd4, 5'd6, 5'd1, 5'd3, 5'd5};
    logic [2:0]  br_f3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [6:0]  fmt_opc [5] = '{7'h13, 7'h23, 7'h63, 7'h37, 7'h6f};
    logic [6:0]  opc_table [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63,
                                  7'h6f, 7'h67, 7'h37, 7'h17};

    id_stage_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .instruction (instruction),
        .pc          (pc),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_bundle   (ex_bundle),
        .if_ctrl     (if_ctrl)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] rand_pc();
        return xorshift32() & 32'hFFFF_FFFC;
    endfunction

    // Expected decode result from the RV32I encoding rules
    function automatic expect_t predict(input logic [31:0] instr, input logic [31:0] pc_v);
        expect_t    e;
        dec_ctrl_t  c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [31:0] a;
        logic [31:0] b;
        logic       cond;

        opc = instr[6:0];
        f3  = instr[14:12];
        a   = shadow[instr[19:15]];
        b   = shadow[instr[24:20]];
        e   = '0;

        c           = '0;
        c.is_branch = (opc == 7'h63);
        c.is_jal    = (opc == 7'h6f);
        c.is_jalr   = (opc == 7'h67);
        c.reg_write = !(opc inside {7'h23, 7'h63});
        case (opc)
            7'h13, 7'h03, 7'h67: c.imm_fmt = imm_i;
            7'h23:               c.imm_fmt = imm_s;
            7'h63:               c.imm_fmt = imm_b;
            7'h37, 7'h17:        c.imm_fmt = imm_u;
            7'h6f:               c.imm_fmt = imm_j;
            default:             c.imm_fmt = imm_none;
        endcase
        c.illegal = !(opc inside {7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67,
                                  7'h37, 7'h17}) || (c.is_branch && f3[2:1] == 2'b01);
        if (c.illegal) begin
            {c.is_branch, c.is_jal, c.is_jalr, c.reg_write} = 4'b0000;
        end

        // Left-align the immediate bits, then shift back with sign
        case (c.imm_fmt)
            imm_i: e.b.imm = $signed(instr) >>> 20;
            imm_s: e.b.imm = $signed({instr[31:25], instr[11:7], 20'h0}) >>> 20;
            imm_b: e.b.imm = $signed({instr[31], instr[7], instr[30:25], instr[11:8],
                                      1'b0, 19'h0}) >>> 19;
            imm_u: e.b.imm = {instr[31:12], 12'h000};
            imm_j: e.b.imm = $signed({instr[31], instr[19:12], instr[20], instr[30:21],
                                      1'b0, 11'h0}) >>> 11;
            default: e.b.imm = 32'h0;
        endcase

        case (f3)
            3'd0:    cond = (a == b);
            3'd1:    cond = (a != b);
            3'd4:    cond = ($signed(a) < $signed(b));
            3'd5:    cond = ($signed(a) >= $signed(b));
            3'd6:    cond = (a < b);
            3'd7:    cond = (a >= b);
            default: cond = 1'b0;
        endcase

        e.c.redirect = c.is_jal | c.is_jalr | (c.is_branch & cond);
        if (c.is_jalr) begin
            e.c.target = (a + e.b.imm) & 32'hFFFF_FFFE;
        end else begin
            e.c.target = pc_v + e.b.imm;
        end

        e.b.pc       = pc_v;
        e.b.rs1_data = a;
        e.b.rs2_data = b;
        e.b.rd       = instr[11:7];
        e.b.funct3   = t_funct3'(f3);
        e.b.funct7   = instr[31:25];
        e.b.ctrl     = c;
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_cycle(input logic v, input logic [31:0] instr, input logic [31:0] pc_v,
                               input logic we, input logic [4:0] rd, input logic [31:0] data);
        @(posedge clk);
        id_valid    <= v;
        instruction <= instr;
        pc          <= pc_v;
        wb_we       <= we;
        wb_rd       <= rd;
        wb_data     <= data;
    endtask

    // A stale JAL on the bus while id_valid is low
    task automatic idle_cycle();
        drive_cycle(1'b0, 32'h0000_006f, 32'h0000_0100, 1'b0, 5'd0, 32'h0);
    endtask

    task automatic read_regs(input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic we, input logic [4:0] rd, input logic [31:0] data);
        drive_cycle(1'b1, {7'h00, rs2, rs1, 3'b000, 5'd3, 7'h33}, rand_pc(), we, rd, data);
    endtask

    // Outputs of the item strobed one edge ago, then prediction for the current inputs
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (rst_n) begin
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_field("ex_valid", {31'h0, ex_valid}, 32'h1);
                compare_field("if_ctrl.redirect", {31'h0, if_ctrl.redirect},
                              {31'h0, e.c.redirect});
                compare_field("if_ctrl.target", if_ctrl.target, e.c.target);
                compare_field("ex_bundle.pc", ex_bundle.pc, e.b.pc);
                compare_field("ex_bundle.imm", ex_bundle.imm, e.b.imm);
                compare_field("ex_bundle.rs1_data", ex_bundle.rs1_data, e.b.rs1_data);
                compare_field("ex_bundle.rs2_data", ex_bundle.rs2_data, e.b.rs2_data);
                compare_field("ex_bundle.rd", {27'h0, ex_bundle.rd}, {27'h0, e.b.rd});
                compare_field("ex_bundle.funct3", {29'h0, ex_bundle.funct3}, {29'h0, e.b.funct3});
                compare_field("ex_bundle.funct7", {25'h0, ex_bundle.funct7}, {25'h0, e.b.funct7});
                compare_field("ex_bundle.ctrl", {24'h0, ex_bundle.ctrl}, {24'h0, e.b.ctrl});
            end else begin
                compare_field("ex_valid", {31'h0, ex_valid}, 32'h0);
                compare_field("if_ctrl.redirect", {31'h0, if_ctrl.redirect}, 32'h0);
            end
            if (id_valid) begin
                exp_q.push_back(predict(instruction, pc));
            end
            // Write lands at the coming edge, after this cycle's read
            if (wb_we && wb_rd != 5'd0) begin
                shadow[wb_rd] = wb_data;
            end
        end
    end

    initial begin : watchdog
        #((stim_cycles + 50) * period_ns);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int          k;
        int          f;
        logic [31:0] r;
        logic [31:0] val;
        logic [6:0]  opc;

        rst_n       = 1'b0;
        id_valid    = 1'b0;
        instruction = 32'h0;
        pc          = 32'h0;
        wb_we       = 1'b0;
        wb_rd       = 5'd0;
        wb_data     = 32'h0;
        foreach (shadow[i]) begin
            shadow[i] = 32'h0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // Idle cycles, then every register reads zero
        idle_cycle();
        idle_cycle();
        for (k = 0; k < 32; k++) begin
            read_regs(k[4:0], ~k[4:0], 1'b0, 5'd0, 32'h0);
        end

        // Write-back followed by a read of the same register
        for (k = 0; k < 40; k++) begin
            r   = xorshift32();
            val = xorshift32();
            drive_cycle(1'b0, 32'h0, 32'h0, 1'b1, r[4:0], val);
            read_regs(r[4:0], r[9:5], 1'b0, 5'd0, 32'h0);
        end
        drive_cycle(1'b0, 32'h0, 32'h0, 1'b1, 5'd0, xorshift32());
        read_regs(5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
        // Same-edge write is seen only by the following read
        read_regs(5'd5, 5'd5, 1'b1, 5'd5, xorshift32());
        read_regs(5'd5, 5'd5, 1'b0, 5'd0, 32'h0);

        // Immediates for I, S, B, U and J, then R-type without one
        for (f = 0; f < 5; f++) begin
            for (k = 0; k < 20; k++) begin
                r = xorshift32();
                drive_cycle(1'b1, {r[31:7], fmt_opc[f]}, rand_pc(), 1'b0, 5'd0, 32'h0);
            end
        end
        for (k = 0; k < 10; k++) begin
            r = xorshift32();
            drive_cycle(1'b1, {r[31:7], 7'h33}, rand_pc(), 1'b0, 5'd0, 32'h0);
        end

        // Branches over equal, signed-negative and unsigned-large pairs
        for (k = 1; k < 7; k++) begin
            drive_cycle(1'b0, 32'h0, 32'h0, 1'b1, k[4:0], br_val[k]);
        end
        for (f = 0; f < 6; f++) begin
            for (k = 0; k < 6; k++) begin
                r = xorshift32();
                drive_cycle(1'b1, {r[31:25], br_rs2[k], br_rs1[k], br_f3[f], r[11:7], 7'h63},
                            rand_pc(), 1'b0, 5'd0, 32'h0);
            end
        end
        for (f = 2; f < 4; f++) begin
            r = xorshift32();
            drive_cycle(1'b1, {r[31:25], 5'd1, 5'd2, f[2:0], r[11:7], 7'h63},
                        rand_pc(), 1'b0, 5'd0, 32'h0);
        end

        // JAL, JALR, and opcodes outside RV32I
        for (k = 0; k < 10; k++) begin
            r = xorshift32();
            drive_cycle(1'b1, {r[31:7], 7'h6f}, rand_pc(), 1'b0, 5'd0, 32'h0);
        end
        for (k = 0; k < 10; k++) begin
            r = xorshift32();
            drive_cycle(1'b1, {r[31:15], 3'b000, r[11:7], 7'h67}, rand_pc(), 1'b0, 5'd0, 32'h0);
        end
        for (k = 0; k < 10; k++) begin
            r = xorshift32();
            drive_cycle(1'b1, {r[31:7], r[6:2], 2'b10}, rand_pc(), 1'b0, 5'd0, 32'h0);
        end

        // Back-to-back stream with interleaved write-backs
        for (k = 0; k < num_rand; k++) begin
            r   = xorshift32();
            opc = (r[7:4] < 4'd9) ? opc_table[r[7:4]] : r[14:8];
            val = xorshift32();
            drive_cycle(r[2:0] != 3'b000, {val[31:7], opc}, rand_pc(),
                        r[15], r[20:16], xorshift32());
        end

        idle_cycle();
        idle_cycle();
        idle_cycle();
        @(posedge clk);
        #1;
        $display("No errors");
        $finish;
    end

endmodule

// File: build.f
common/riscv_pkg.sv
decode/control_unit.sv
decode/imm_gen.sv
decode/register_file.sv
decode/bu.sv
decode/dec.sv
source/id_stage_top.sv
dv/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f build.f --top-module tb_id_stage -o tb_id_stage \
    > build.log 2>&1 &&
    ./obj_dir/tb_id_stage > sim.log 2>&1 ||
    echo "Build or simulation returned a failing status, see build.log and sim.log"

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
